//--- verilog/battleship_pkg.sv
package battleship_pkg;

	// Board edge length in cells
	localparam int BOARD_SIZE = 5;

	// Highest ship count a confirm can set
	localparam int MAX_SHIPS = 5;

	// Shots held between the cursor and the referee
	localparam int QUEUE_DEPTH = 4;

	// Pointer width for the shot buffer
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

	// Row or column index
	typedef logic [2:0] coord_t;

	// Ship count wide enough for the raw switch value 0 to 7
	typedef logic [2:0] ship_count_t;

	// Seven-segment pattern active high with segment a in bit 0
	typedef logic [6:0] seg_t;

	// Last row and last column of the board
	localparam coord_t COORD_MAX = coord_t'(BOARD_SIZE - 1);

	// Clamp value for the confirmed ship count
	localparam ship_count_t SHIP_LIMIT = ship_count_t'(MAX_SHIPS);

	// Grade of one shot
	typedef enum logic [1:0] {
		SHOT_MISS   = 2'd0,
		SHOT_HIT    = 2'd1,
		SHOT_REPEAT = 2'd2
	} shot_result_t;

	// Referee game flow
	typedef enum logic [1:0] {
		GAME_SETUP = 2'd0,
		GAME_PLAY  = 2'd1,
		GAME_WON   = 2'd2
	} game_state_t;

	// Fixed fleet with one cell per ship
	// Entry k is used when the confirmed count is above k
	// Cells (0,0) (1,3) (2,1) (3,4) (4,2)
	localparam coord_t FLEET_ROW [MAX_SHIPS] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4};
	localparam coord_t FLEET_COL [MAX_SHIPS] = '{3'd0, 3'd3, 3'd1, 3'd4, 3'd2};

endpackage

//--- verilog/cursor_control.sv
`timescale 1ns/1ps

module cursor_control (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_move_up,
	input  logic                   i_move_down,
	input  logic                   i_move_left,
	input  logic                   i_move_right,
	input  logic                   i_fire,
	input  logic                   i_ack,
	output logic                   o_req,
	output battleship_pkg::coord_t o_row,
	output battleship_pkg::coord_t o_col,
	output battleship_pkg::coord_t o_cursor_row,
	output battleship_pkg::coord_t o_cursor_col
);

	// Button levels seen on the previous clock
	logic up_q;
	logic down_q;
	logic left_q;
	logic right_q;
	logic fire_q;

	// One-cycle rising edges
	logic up_edge;
	logic down_edge;
	logic left_edge;
	logic right_edge;
	logic fire_edge;

	// Handshake still running until the queue drops its ack
	logic shot_open;

	assign up_edge    = i_move_up & ~up_q;
	assign down_edge  = i_move_down & ~down_q;
	assign left_edge  = i_move_left & ~left_q;
	assign right_edge = i_move_right & ~right_q;
	assign fire_edge  = i_fire & ~fire_q;
	assign shot_open  = o_req | i_ack;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			up_q    <= 1'b0;
			down_q  <= 1'b0;
			left_q  <= 1'b0;
			right_q <= 1'b0;
			fire_q  <= 1'b0;
		end else begin
			up_q    <= i_move_up;
			down_q  <= i_move_down;
			left_q  <= i_move_left;
			right_q <= i_move_right;
			fire_q  <= i_fire;
		end
	end

	// Up lowers the row, down raises it
	// Both stop at the edge without wrapping
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_cursor_row <= '0;
		end else if (up_edge) begin
			if (o_cursor_row != '0)
				o_cursor_row <= o_cursor_row - 3'd1;
		end else if (down_edge) begin
			if (o_cursor_row != battleship_pkg::COORD_MAX)
				o_cursor_row <= o_cursor_row + 3'd1;
		end
	end

	// Same saturation for the column
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_cursor_col <= '0;
		end else if (left_edge) begin
			if (o_cursor_col != '0)
				o_cursor_col <= o_cursor_col - 3'd1;
		end else if (right_edge) begin
			if (o_cursor_col != battleship_pkg::COORD_MAX)
				o_cursor_col <= o_cursor_col + 3'd1;
		end
	end

	// Four-phase request
	// Raise on a fire edge when idle, drop once ack is seen
	// A fire edge during an open handshake is lost
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_req <= 1'b0;
		end else if (o_req && i_ack) begin
			o_req <= 1'b0;
		end else if (fire_edge && !shot_open) begin
			o_req <= 1'b1;
		end
	end

	// Shot cell held stable for the whole request
	always_ff @(posedge i_clk) begin
		if (fire_edge && !shot_open) begin
			o_row <= o_cursor_row;
			o_col <= o_cursor_col;
		end
	end

endmodule

//--- verilog/shot_queue.sv
`timescale 1ns/1ps

module shot_queue (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_req_in,
	input  battleship_pkg::coord_t i_row_in,
	input  battleship_pkg::coord_t i_col_in,
	input  logic                   i_ack_out,
	output logic                   o_ack_in,
	output logic                   o_req_out,
	output battleship_pkg::coord_t o_row_out,
	output battleship_pkg::coord_t o_col_out
);

	// Write side sequencer
	typedef enum logic {
		WR_IDLE,
		WR_ACK
	} wr_state_t;

	// Read side sequencer
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_REQ,
		RD_RELEASE
	} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;

	// Circular storage of shot cells
	battleship_pkg::coord_t mem_row [battleship_pkg::QUEUE_DEPTH];
	battleship_pkg::coord_t mem_col [battleship_pkg::QUEUE_DEPTH];

	logic [battleship_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [battleship_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [battleship_pkg::QUEUE_PTR_W:0]   count;

	logic full;
	logic push;
	logic pop;

	assign full = (count == battleship_pkg::QUEUE_DEPTH);
	// Entry taken on the clock that raises ack
	assign push = (wr_state == WR_IDLE) && i_req_in && !full;
	// Head leaves once the consumer's ack has come back down
	assign pop  = (rd_state == RD_RELEASE) && !i_ack_out;

	assign o_ack_in  = (wr_state == WR_ACK);
	assign o_req_out = (rd_state == RD_REQ);
	assign o_row_out = mem_row[rd_ptr];
	assign o_col_out = mem_col[rd_ptr];

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_state <= WR_IDLE;
		end else if (wr_state == WR_IDLE) begin
			if (push)
				wr_state <= WR_ACK;
		end else if (!i_req_in) begin
			wr_state <= WR_IDLE;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				// Present the head one cycle after it was written
				RD_IDLE: if (count != '0) rd_state <= RD_REQ;
				RD_REQ: if (i_ack_out) rd_state <= RD_RELEASE;
				RD_RELEASE: if (!i_ack_out) rd_state <= RD_IDLE;
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (push) begin
			mem_row[wr_ptr] <= i_row_in;
			mem_col[wr_ptr] <= i_col_in;
		end
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

//--- verilog/board_referee.sv
`timescale 1ns/1ps

module board_referee (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  battleship_pkg::ship_count_t  i_ship_count,
	input  logic                         i_confirm,
	input  logic                         i_req,
	input  battleship_pkg::coord_t       i_row,
	input  battleship_pkg::coord_t       i_col,
	output logic                         o_ack,
	output logic                         o_shot_valid,
	output battleship_pkg::shot_result_t o_shot_result,
	output battleship_pkg::coord_t       o_shot_row,
	output battleship_pkg::coord_t       o_shot_col,
	output battleship_pkg::ship_count_t  o_ships_left,
	output battleship_pkg::seg_t         o_seg,
	output logic                         o_victory,
	output battleship_pkg::game_state_t  o_game_state
);

	battleship_pkg::game_state_t state;

	// Computer board with one ship bit and one fired bit per cell
	logic ship_cell  [battleship_pkg::BOARD_SIZE][battleship_pkg::BOARD_SIZE];
	logic fired_cell [battleship_pkg::BOARD_SIZE][battleship_pkg::BOARD_SIZE];

	battleship_pkg::ship_count_t ships_clamped;
	logic load_board;
	logic take_shot;
	logic cell_ship;
	logic cell_fired;

	// Switch values above the limit count as the limit
	assign ships_clamped = (i_ship_count > battleship_pkg::SHIP_LIMIT) ?
		battleship_pkg::SHIP_LIMIT : i_ship_count;

	assign load_board = (state == battleship_pkg::GAME_SETUP) && i_confirm;
	// New request graded only during play
	assign take_shot  = (state == battleship_pkg::GAME_PLAY) && i_req && !o_ack;
	assign cell_ship  = ship_cell[i_row][i_col];
	assign cell_fired = fired_cell[i_row][i_col];

	assign o_victory    = (state == battleship_pkg::GAME_WON);
	assign o_game_state = state;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state        <= battleship_pkg::GAME_SETUP;
			o_ships_left <= '0;
			o_ack        <= 1'b0;
			o_shot_valid <= 1'b0;
		end else begin
			// Valid pulses on the same clock that raises ack
			o_shot_valid <= take_shot;
			if (take_shot)
				o_ack <= 1'b1;
			else if (o_ack && !i_req)
				o_ack <= 1'b0;

			if (load_board) begin
				o_ships_left <= ships_clamped;
				// No ships means nothing to sink
				if (ships_clamped == '0)
					state <= battleship_pkg::GAME_WON;
				else
					state <= battleship_pkg::GAME_PLAY;
			end else if (take_shot && cell_ship && !cell_fired) begin
				o_ships_left <= o_ships_left - 3'd1;
				// Last ship afloat just went down
				if (o_ships_left == 3'd1)
					state <= battleship_pkg::GAME_WON;
			end
		end
	end

	// Confirm rebuilds the board from the first N fleet entries
	always_ff @(posedge i_clk) begin
		if (load_board) begin
			for (int r = 0; r < battleship_pkg::BOARD_SIZE; r++) begin
				for (int c = 0; c < battleship_pkg::BOARD_SIZE; c++) begin
					ship_cell[r][c]  <= 1'b0;
					fired_cell[r][c] <= 1'b0;
				end
			end
			for (int k = 0; k < battleship_pkg::MAX_SHIPS; k++) begin
				if (k < ships_clamped)
					ship_cell[battleship_pkg::FLEET_ROW[k]][battleship_pkg::FLEET_COL[k]] <= 1'b1;
			end
		end else if (take_shot) begin
			fired_cell[i_row][i_col] <= 1'b1;
		end
	end

	// Grade and cell of the last shot
	always_ff @(posedge i_clk) begin
		if (take_shot) begin
			o_shot_row <= i_row;
			o_shot_col <= i_col;
			if (cell_fired)
				o_shot_result <= battleship_pkg::SHOT_REPEAT;
			else if (cell_ship)
				o_shot_result <= battleship_pkg::SHOT_HIT;
			else
				o_shot_result <= battleship_pkg::SHOT_MISS;
		end
	end

	// Ships left as a decimal digit
	always_comb begin
		case (o_ships_left)
			3'd0: o_seg = 7'h3F;
			3'd1: o_seg = 7'h06;
			3'd2: o_seg = 7'h5B;
			3'd3: o_seg = 7'h4F;
			3'd4: o_seg = 7'h66;
			3'd5: o_seg = 7'h6D;
			// Dash for a count out of range
			default: o_seg = 7'h40;
		endcase
	end

endmodule

//--- verilog/battleship_top.sv
`timescale 1ns/1ps

module battleship_top (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  logic                         i_move_up,
	input  logic                         i_move_down,
	input  logic                         i_move_left,
	input  logic                         i_move_right,
	input  logic                         i_fire,
	input  battleship_pkg::ship_count_t  i_ship_count,
	input  logic                         i_confirm,
	output battleship_pkg::coord_t       o_cursor_row,
	output battleship_pkg::coord_t       o_cursor_col,
	output logic                         o_shot_valid,
	output battleship_pkg::shot_result_t o_shot_result,
	output battleship_pkg::coord_t       o_shot_row,
	output battleship_pkg::coord_t       o_shot_col,
	output battleship_pkg::ship_count_t  o_ships_left,
	output battleship_pkg::seg_t         o_seg,
	output logic                         o_victory,
	output battleship_pkg::game_state_t  o_game_state
);

	// Cursor to buffer handshake
	logic                   fire_req;
	logic                   fire_ack;
	battleship_pkg::coord_t fire_row;
	battleship_pkg::coord_t fire_col;

	// Buffer to referee handshake
	logic                   grade_req;
	logic                   grade_ack;
	battleship_pkg::coord_t grade_row;
	battleship_pkg::coord_t grade_col;

	cursor_control u_cursor_control (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_move_up    (i_move_up),
		.i_move_down  (i_move_down),
		.i_move_left  (i_move_left),
		.i_move_right (i_move_right),
		.i_fire       (i_fire),
		.i_ack        (fire_ack),
		.o_req        (fire_req),
		.o_row        (fire_row),
		.o_col        (fire_col),
		.o_cursor_row (o_cursor_row),
		.o_cursor_col (o_cursor_col)
	);

	shot_queue u_shot_queue (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_req_in  (fire_req),
		.i_row_in  (fire_row),
		.i_col_in  (fire_col),
		.i_ack_out (grade_ack),
		.o_ack_in  (fire_ack),
		.o_req_out (grade_req),
		.o_row_out (grade_row),
		.o_col_out (grade_col)
	);

	// Referee holds ack low outside play so shots wait in the buffer
	board_referee u_board_referee (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_ship_count  (i_ship_count),
		.i_confirm     (i_confirm),
		.i_req         (grade_req),
		.i_row         (grade_row),
		.i_col         (grade_col),
		.o_ack         (grade_ack),
		.o_shot_valid  (o_shot_valid),
		.o_shot_result (o_shot_result),
		.o_shot_row    (o_shot_row),
		.o_shot_col    (o_shot_col),
		.o_ships_left  (o_ships_left),
		.o_seg         (o_seg),
		.o_victory     (o_victory),
		.o_game_state  (o_game_state)
	);

endmodule

//--- bench/battleship_properties.sv
`timescale 1ns/1ps

module battleship_properties #(
	parameter bit CHECK_SHIPS = 1'b0
) (
	input logic                        i_clk,
	input logic                        i_rst_n,
	input logic                        i_req,
	input logic                        i_ack,
	input battleship_pkg::ship_count_t i_ships_left,
	input battleship_pkg::game_state_t i_game_state
);

	// Failed assertions in this instance
	int fail_count = 0;

	// Requester keeps req up until the ack comes back
	req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_req && !i_ack) |=> i_req)
		else begin
			$error("req dropped before ack");
			fail_count++;
		end

	// Ack only answers an open request
	ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_ack) |-> i_req)
		else begin
			$error("ack rose without req");
			fail_count++;
		end

	// During play the count only goes down
	ships_not_rising: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(CHECK_SHIPS && i_game_state == battleship_pkg::GAME_PLAY)
		|=> (i_ships_left <= $past(i_ships_left)))
		else begin
			$error("ships left increased during play");
			fail_count++;
		end

endmodule

// Cursor to buffer handshake as seen from the buffer
bind shot_queue battleship_properties u_queue_props (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_req        (i_req_in),
	.i_ack        (o_ack_in),
	.i_ships_left (3'd0),
	.i_game_state (battleship_pkg::GAME_SETUP)
);

// Buffer to referee handshake and the ship counter
bind board_referee battleship_properties #(.CHECK_SHIPS(1'b1)) u_referee_props (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_req        (i_req),
	.i_ack        (o_ack),
	.i_ships_left (o_ships_left),
	.i_game_state (o_game_state)
);

//--- bench/battleship_tb.sv
`timescale 1ns/1ps

module battleship_tb;

	// Short names for the table
	localparam battleship_pkg::shot_result_t MISS = battleship_pkg::SHOT_MISS;
	localparam battleship_pkg::shot_result_t HIT = battleship_pkg::SHOT_HIT;
	localparam battleship_pkg::shot_result_t RPT = battleship_pkg::SHOT_REPEAT;
	localparam battleship_pkg::game_state_t SETUP = battleship_pkg::GAME_SETUP;
	localparam battleship_pkg::game_state_t PLAY = battleship_pkg::GAME_PLAY;
	localparam battleship_pkg::game_state_t WON = battleship_pkg::GAME_WON;

	// FIRE_Q fires before confirm, GRADE waits for a queued shot
	typedef enum logic [2:0] {
		ACT_UP,
		ACT_DOWN,
		ACT_LEFT,
		ACT_RIGHT,
		ACT_FIRE_Q,
		ACT_FIRE,
		ACT_GRADE,
		ACT_CONFIRM
	} action_t;

	typedef struct packed {
		action_t                      act;
		battleship_pkg::ship_count_t  count;
		battleship_pkg::coord_t       cur_row;
		battleship_pkg::coord_t       cur_col;
		battleship_pkg::shot_result_t result;
		battleship_pkg::coord_t       shot_row;
		battleship_pkg::coord_t       shot_col;
		battleship_pkg::ship_count_t  ships;
		battleship_pkg::game_state_t  state;
	} step_t;

	localparam int NUM_STEPS = 40;
	localparam int TIMEOUT_CYCLES = NUM_STEPS * 64;

	// Digits 0 to 5 with segment a in bit 0
	localparam battleship_pkg::seg_t DIGIT_SEG [6] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D
	};

	localparam step_t RESET_STEP = '{ACT_GRADE, 3'd0, 3'd0, 3'd0, MISS, 3'd0, 3'd0, 3'd0, SETUP};

	// Action, ship count, cursor row and col, result, shot row and col, ships left, state
	localparam step_t STEPS [NUM_STEPS] = '{
		'{ACT_LEFT,    3'd0, 3'd0, 3'd0, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_UP,      3'd0, 3'd0, 3'd0, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_RIGHT,   3'd0, 3'd0, 3'd1, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_RIGHT,   3'd0, 3'd0, 3'd2, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_RIGHT,   3'd0, 3'd0, 3'd3, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_RIGHT,   3'd0, 3'd0, 3'd4, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_RIGHT,   3'd0, 3'd0, 3'd4, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_DOWN,    3'd0, 3'd1, 3'd4, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_DOWN,    3'd0, 3'd2, 3'd4, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_DOWN,    3'd0, 3'd3, 3'd4, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_DOWN,    3'd0, 3'd4, 3'd4, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_DOWN,    3'd0, 3'd4, 3'd4, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		// Three shots wait in the buffer until confirm
		'{ACT_FIRE_Q,  3'd0, 3'd4, 3'd4, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_UP,      3'd0, 3'd3, 3'd4, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_FIRE_Q,  3'd0, 3'd3, 3'd4, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_LEFT,    3'd0, 3'd3, 3'd3, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		'{ACT_FIRE_Q,  3'd0, 3'd3, 3'd3, MISS, 3'd0, 3'd0, 3'd0, SETUP},
		// Switch value 7 clamps to 5 ships
		'{ACT_CONFIRM, 3'd7, 3'd3, 3'd3, MISS, 3'd0, 3'd0, 3'd5, PLAY},
		'{ACT_GRADE,   3'd0, 3'd3, 3'd3, MISS, 3'd4, 3'd4, 3'd5, PLAY},
		'{ACT_GRADE,   3'd0, 3'd3, 3'd3, HIT,  3'd3, 3'd4, 3'd4, PLAY},
		'{ACT_GRADE,   3'd0, 3'd3, 3'd3, MISS, 3'd3, 3'd3, 3'd4, PLAY},
		'{ACT_UP,      3'd0, 3'd2, 3'd3, MISS, 3'd0, 3'd0, 3'd4, PLAY},
		'{ACT_UP,      3'd0, 3'd1, 3'd3, MISS, 3'd0, 3'd0, 3'd4, PLAY},
		'{ACT_FIRE,    3'd0, 3'd1, 3'd3, HIT,  3'd1, 3'd3, 3'd3, PLAY},
		'{ACT_FIRE,    3'd0, 3'd1, 3'd3, RPT,  3'd1, 3'd3, 3'd3, PLAY},
		'{ACT_LEFT,    3'd0, 3'd1, 3'd2, MISS, 3'd0, 3'd0, 3'd3, PLAY},
		'{ACT_LEFT,    3'd0, 3'd1, 3'd1, MISS, 3'd0, 3'd0, 3'd3, PLAY},
		'{ACT_DOWN,    3'd0, 3'd2, 3'd1, MISS, 3'd0, 3'd0, 3'd3, PLAY},
		'{ACT_FIRE,    3'd0, 3'd2, 3'd1, HIT,  3'd2, 3'd1, 3'd2, PLAY},
		'{ACT_DOWN,    3'd0, 3'd3, 3'd1, MISS, 3'd0, 3'd0, 3'd2, PLAY},
		'{ACT_DOWN,    3'd0, 3'd4, 3'd1, MISS, 3'd0, 3'd0, 3'd2, PLAY},
		'{ACT_RIGHT,   3'd0, 3'd4, 3'd2, MISS, 3'd0, 3'd0, 3'd2, PLAY},
		'{ACT_FIRE,    3'd0, 3'd4, 3'd2, HIT,  3'd4, 3'd2, 3'd1, PLAY},
		'{ACT_UP,      3'd0, 3'd3, 3'd2, MISS, 3'd0, 3'd0, 3'd1, PLAY},
		'{ACT_UP,      3'd0, 3'd2, 3'd2, MISS, 3'd0, 3'd0, 3'd1, PLAY},
		'{ACT_UP,      3'd0, 3'd1, 3'd2, MISS, 3'd0, 3'd0, 3'd1, PLAY},
		'{ACT_UP,      3'd0, 3'd0, 3'd2, MISS, 3'd0, 3'd0, 3'd1, PLAY},
		'{ACT_LEFT,    3'd0, 3'd0, 3'd1, MISS, 3'd0, 3'd0, 3'd1, PLAY},
		'{ACT_LEFT,    3'd0, 3'd0, 3'd0, MISS, 3'd0, 3'd0, 3'd1, PLAY},
		// Last ship sinks and the game is over
		'{ACT_FIRE,    3'd0, 3'd0, 3'd0, HIT,  3'd0, 3'd0, 3'd0, WON}
	};

	logic clk;
	logic rst_n;
	logic move_up;
	logic move_down;
	logic move_left;
	logic move_right;
	logic fire;
	logic confirm;
	battleship_pkg::ship_count_t  ship_count;
	battleship_pkg::coord_t       cursor_row;
	battleship_pkg::coord_t       cursor_col;
	logic                         shot_valid;
	battleship_pkg::shot_result_t shot_result;
	battleship_pkg::coord_t       shot_row;
	battleship_pkg::coord_t       shot_col;
	battleship_pkg::ship_count_t  ships_left;
	battleship_pkg::seg_t         seg;
	logic                         victory;
	battleship_pkg::game_state_t  game_state;
	int unsigned                  cycle_count;

	battleship_top u_battleship_top (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_move_up     (move_up),
		.i_move_down   (move_down),
		.i_move_left   (move_left),
		.i_move_right  (move_right),
		.i_fire        (fire),
		.i_ship_count  (ship_count),
		.i_confirm     (confirm),
		.o_cursor_row  (cursor_row),
		.o_cursor_col  (cursor_col),
		.o_shot_valid  (shot_valid),
		.o_shot_result (shot_result),
		.o_shot_row    (shot_row),
		.o_shot_col    (shot_col),
		.o_ships_left  (ships_left),
		.o_seg         (seg),
		.o_victory     (victory),
		.o_game_state  (game_state)
	);

	always #4 clk = ~clk;

	task automatic abort_run;
		$display("Test failed");
		$fatal(1);
	endtask

	function automatic int assert_failures();
		return u_battleship_top.u_shot_queue.u_queue_props.fail_count +
			u_battleship_top.u_board_referee.u_referee_props.fail_count;
	endfunction

	// Run limit in clock cycles
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout waiting for shot result");
			abort_run();
		end
	end

	// Stop as soon as a bound assertion fires
	always @(negedge clk) begin
		if (assert_failures() != 0) begin
			$display("a handshake or ship count assertion failed");
			abort_run();
		end
	end

	task automatic check_coord(input string name, input battleship_pkg::coord_t expected,
		input battleship_pkg::coord_t actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_result(input string name, input battleship_pkg::shot_result_t expected,
		input battleship_pkg::shot_result_t actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input battleship_pkg::ship_count_t expected,
		input battleship_pkg::ship_count_t actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_seg(input string name, input battleship_pkg::seg_t expected,
		input battleship_pkg::seg_t actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_state(input string name, input battleship_pkg::game_state_t expected,
		input battleship_pkg::game_state_t actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
			abort_run();
		end
	endtask

	// One-cycle button pulse seen by the DUT on the second edge
	task automatic pulse_button(input action_t act, input battleship_pkg::ship_count_t count);
		@(posedge clk);
		case (act)
			ACT_UP: move_up <= 1'b1;
			ACT_DOWN: move_down <= 1'b1;
			ACT_LEFT: move_left <= 1'b1;
			ACT_RIGHT: move_right <= 1'b1;
			ACT_FIRE_Q, ACT_FIRE: fire <= 1'b1;
			ACT_CONFIRM: begin
				ship_count <= count;
				confirm    <= 1'b1;
			end
			default: ;
		endcase
		@(posedge clk);
		move_up    <= 1'b0;
		move_down  <= 1'b0;
		move_left  <= 1'b0;
		move_right <= 1'b0;
		fire       <= 1'b0;
		confirm    <= 1'b0;
	endtask

	// Wait for the cursor handshake to close and/or a graded shot
	task automatic await_step(input logic want_ack, input logic want_valid);
		logic ack_seen;
		logic valid_seen;
		logic idle;
		ack_seen   = !want_ack;
		valid_seen = !want_valid;
		idle       = 1'b0;
		while (!(ack_seen && valid_seen && idle)) begin
			@(negedge clk);
			if (u_battleship_top.fire_ack)
				ack_seen = 1'b1;
			if (shot_valid)
				valid_seen = 1'b1;
			// Cursor is free again once req and ack are both low
			idle = !want_ack || (!u_battleship_top.fire_req && !u_battleship_top.fire_ack);
		end
	endtask

	task automatic check_outputs(input step_t step, input logic graded);
		check_coord("o_cursor_row", step.cur_row, cursor_row);
		check_coord("o_cursor_col", step.cur_col, cursor_col);
		check_count("o_ships_left", step.ships, ships_left);
		check_seg("o_seg", DIGIT_SEG[step.ships], seg);
		check_state("o_game_state", step.state, game_state);
		check_flag("o_victory", step.state == WON, victory);
		if (graded) begin
			check_result("o_shot_result", step.result, shot_result);
			check_coord("o_shot_row", step.shot_row, shot_row);
			check_coord("o_shot_col", step.shot_col, shot_col);
		end else begin
			// No shot may be graded outside a fire or grade step
			check_flag("o_shot_valid", 1'b0, shot_valid);
		end
	endtask

	task automatic run_step(input step_t step);
		logic graded;
		graded = (step.act == ACT_FIRE) || (step.act == ACT_GRADE);
		if (step.act != ACT_GRADE)
			pulse_button(step.act, step.count);
		case (step.act)
			ACT_FIRE_Q: await_step(1'b1, 1'b0);
			ACT_FIRE: await_step(1'b1, 1'b1);
			ACT_GRADE: await_step(1'b0, 1'b1);
			default: @(negedge clk);
		endcase
		check_outputs(step, graded);
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		move_up     = 1'b0;
		move_down   = 1'b0;
		move_left   = 1'b0;
		move_right  = 1'b0;
		fire        = 1'b0;
		confirm     = 1'b0;
		ship_count  = '0;
		cycle_count = 0;
		// Eight edges with reset low
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_outputs(RESET_STEP, 1'b0);
		@(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < NUM_STEPS; i++)
			run_step(STEPS[i]);
		if (assert_failures() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

//--- project.f
verilog/battleship_pkg.sv
verilog/cursor_control.sv
verilog/shot_queue.sv
verilog/board_referee.sv
verilog/battleship_top.sv
bench/battleship_properties.sv
bench/battleship_tb.sv
